/* design/sysarr_pkg.sv */
/*
 * shared constants and vector types for the systolic-array writeback stage
 * lane count, element and address widths, staircase masks
 */
package sysarr_pkg;

    localparam int DIM       = 16;            // lanes, banks and rows per block
    localparam int ELEM_W    = 8;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 1 << ADDR_W;   // 16 blocks per bank
    localparam int ROW_W     = $clog2(DIM);

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DIM-1:0]    lane_mask_t;   // one enable bit per bank

    // lane 0 sits in the low bits of both vectors
    typedef elem_t [DIM-1:0] row_t;
    typedef addr_t [DIM-1:0] lane_addr_t;

    // staircase landmarks
    localparam lane_mask_t MASK_RAMP_TOP = {1'b0, {(DIM-1){1'b1}}}; // last step before all ones
    localparam lane_mask_t MASK_LAST     = {1'b1, {(DIM-1){1'b0}}}; // only the top bank left

    localparam int ROW_LAST = DIM - 1;

endpackage

/* design/wr_control.sv */
/*
 * write controller for the skewed array output
 * staircase bank enables, per-bank offsets and the done level
 */
`timescale 1ns/1ps

module wr_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   active,          // start of a write pass
    input  logic                   sys_arr_active,  // array busy again, drops done
    output sysarr_pkg::lane_mask_t wr_en,
    output sysarr_pkg::lane_addr_t wr_addr,         // offset from the block base
    output logic                   done
);
    import sysarr_pkg::*;

    logic       act_q;
    logic       wr_start, wr_start_c;
    logic       wr_dec, wr_dec_c;     // ramp-down phase
    logic       done_c;
    lane_mask_t wr_en_c;
    lane_addr_t wr_addr_c;

    always_ff @(posedge clk) begin
        if (reset) begin
            act_q    <= 1'b0;
            wr_start <= 1'b0;
            wr_dec   <= 1'b0;
            wr_en    <= '0;
            wr_addr  <= '0;
            done     <= 1'b0;
        end else begin
            act_q    <= active;
            wr_start <= wr_start_c;
            wr_dec   <= wr_dec_c;
            wr_en    <= wr_en_c;
            wr_addr  <= wr_addr_c;
            done     <= done_c;
        end
    end

    always_comb begin
        wr_en_c    = '0;
        wr_addr_c  = wr_addr;
        wr_dec_c   = wr_dec;
        wr_start_c = wr_start;
        done_c     = done;

        if (wr_start) begin
            if (wr_en == MASK_RAMP_TOP)
                wr_dec_c = 1'b1;           // next step is all ones, then shift zeros in

            if (wr_dec)
                wr_en_c = wr_en << 1;
            else
                wr_en_c = (wr_en << 1) | lane_mask_t'(1);

            // each bank advances after a cycle with its enable high
            for (int i = 0; i < DIM; i++)
                wr_addr_c[i] = wr_addr[i] + addr_t'(wr_en[i]);

            if (wr_dec && wr_en == '0) begin  // staircase finished
                wr_start_c = 1'b0;
                wr_dec_c   = 1'b0;
                wr_addr_c  = '0;
            end
        end

        if (act_q)
            wr_start_c = 1'b1;

        if (active)
            done_c = 1'b0;
        if (wr_en == MASK_LAST)
            done_c = 1'b1;                 // top bank takes its last element now
        if (sys_arr_active && done)
            done_c = 1'b0;
    end

endmodule

/* design/rd_control.sv */
/*
 * block reader, one row of all banks per cycle
 * read address, row valid strobe and done pulse
 */
`timescale 1ns/1ps

module rd_control (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_start,
    input  sysarr_pkg::addr_t rd_base,
    output logic              rd_en,
    output sysarr_pkg::addr_t rd_addr,
    output logic              rd_valid,
    output logic              rd_done
);
    import sysarr_pkg::*;

    logic             busy;
    logic [ROW_W-1:0] row;
    addr_t            base_q;   // base held for the whole block

    assign rd_en   = busy;
    assign rd_addr = base_q + addr_t'(row);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            row      <= '0;
            rd_valid <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            rd_valid <= busy;                           // memory output is one cycle late
            rd_done  <= busy && (row == ROW_W'(ROW_LAST));

            if (busy) begin
                if (row == ROW_W'(ROW_LAST)) begin
                    busy <= 1'b0;
                    row  <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else if (rd_start) begin  // ignored while busy
                busy <= 1'b1;
                row  <= '0;
            end
        end
    end

    // captured on the start pulse only
    always_ff @(posedge clk) begin
        if (!busy && rd_start)
            base_q <= rd_base;
    end

endmodule

/* design/mem_arr.sv */
/*
 * result memory, one byte-wide bank per lane
 * independent write enables and offsets, shared registered read
 */
`timescale 1ns/1ps

module mem_arr (
    input  logic                   clk,
    input  sysarr_pkg::lane_mask_t wr_en,
    input  sysarr_pkg::addr_t      wr_base,
    input  sysarr_pkg::lane_addr_t wr_addr,
    input  sysarr_pkg::row_t       wr_data,
    input  logic                   rd_en,
    input  sysarr_pkg::addr_t      rd_addr,
    output sysarr_pkg::row_t       rd_data
);
    import sysarr_pkg::*;

    for (genvar i = 0; i < DIM; i++) begin : g_bank
        elem_t mem [MEM_DEPTH];
        addr_t bank_waddr;

        assign bank_waddr = wr_base + wr_addr[i];   // wraps inside the bank

        always_ff @(posedge clk) begin
            if (wr_en[i])
                mem[bank_waddr] <= wr_data[i];
        end

        // every bank reads the same row
        always_ff @(posedge clk) begin
            if (rd_en)
                rd_data[i] <= mem[rd_addr];
        end
    end

endmodule

/* design/wb_top.sv */
/*
 * writeback stage top level
 * write controller, block reader and banked result memory
 */
`timescale 1ns/1ps

module wb_top (
    input  logic              clk,
    input  logic              reset,
    // array side
    input  logic              active,
    input  logic              sys_arr_active,
    input  sysarr_pkg::addr_t wr_base,        // steady for a whole block
    input  sysarr_pkg::row_t  res_data,       // skewed lane results
    output logic              done,
    // read side
    input  logic              rd_start,
    input  sysarr_pkg::addr_t rd_base,
    output sysarr_pkg::row_t  rd_data,        // de-skewed row
    output logic              rd_valid,
    output logic              rd_done
);
    import sysarr_pkg::*;

    lane_mask_t wr_en;
    lane_addr_t wr_addr;
    logic       rd_en;
    addr_t      rd_addr;

    wr_control u_wr_control (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .sys_arr_active (sys_arr_active),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .done           (done)
    );

    rd_control u_rd_control (
        .clk      (clk),
        .reset    (reset),
        .rd_start (rd_start),
        .rd_base  (rd_base),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_done  (rd_done)
    );

    mem_arr u_mem_arr (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_base (wr_base),
        .wr_addr (wr_addr),
        .wr_data (res_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* tb/wb_top_assert.sv */
/*
 * concurrent checks on the write staircase and the read strobes
 */
`timescale 1ns/1ps

module wb_top_assert (
    input logic                   clk,
    input logic                   reset,
    input sysarr_pkg::lane_mask_t wr_en,
    input logic                   done,
    input logic                   rd_en,
    input logic                   rd_valid,
    input logic                   rd_done
);
    import sysarr_pkg::*;

    int fail_cnt = 0;   // failed assertions so far

    // each step shifts a one or a zero in at bit 0
    a_stair_step: assert property (@(posedge clk) disable iff (reset)
        (wr_en == lane_mask_t'($past(wr_en) << 1)) ||
        (wr_en == lane_mask_t'(($past(wr_en) << 1) | 1'b1)))
        else begin
            fail_cnt++;
            $error("wr_en step from %h to %h is not a shift at bit 0", $past(wr_en), wr_en);
        end

    a_done_after_last: assert property (@(posedge clk) disable iff (reset)
        wr_en == MASK_LAST |=> done)
        else begin
            fail_cnt++;
            $error("done did not rise after the last staircase step");
        end

    a_done_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> $past(wr_en) == MASK_LAST)
        else begin
            fail_cnt++;
            $error("done rose without the last staircase step before it");
        end

    a_rd_done_valid: assert property (@(posedge clk) disable iff (reset)
        rd_done |-> rd_valid)
        else begin
            fail_cnt++;
            $error("rd_done without rd_valid");
        end

    a_valid_latency: assert property (@(posedge clk) disable iff (reset)
        rd_valid == $past(rd_en))
        else begin
            fail_cnt++;
            $error("rd_valid does not follow rd_en by one cycle");
        end

endmodule

/* tb/wb_top_tb.sv */
/*
 * testbench for the writeback stage
 * clock and reset, random skewed blocks, reference memory, compare tasks, watchdog
 */
`timescale 1ns/1ps

module wb_top_tb;
    import sysarr_pkg::*;

    localparam int NUM_BLOCKS  = 6;
    localparam int CLK_HALF    = 5;
    localparam int DRIVE_DLY   = 1;
    localparam int DONE_RISE   = 33;                     // cycles from sampled active to done
    localparam int WDOG_CYCLES = NUM_BLOCKS * 80 + 200;

    logic  clk;
    logic  reset;
    logic  active;
    logic  sys_arr_active;
    addr_t wr_base;
    row_t  res_data;
    logic  done;
    logic  rd_start;
    addr_t rd_base;
    row_t  rd_data;
    logic  rd_valid;
    logic  rd_done;

    integer seed = 32'h56b4;
    int     data_errs;
    int     flag_errs;
    int     count_errs;
    int     assert_errs;

    elem_t ref_mem [DIM][MEM_DEPTH];   // lane, address
    elem_t cur_blk [DIM][DIM];         // lane, element index
    addr_t blk_base [NUM_BLOCKS];
    int    rd_order [NUM_BLOCKS];

    wb_top UUT (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .sys_arr_active (sys_arr_active),
        .wr_base        (wr_base),
        .res_data       (res_data),
        .done           (done),
        .rd_start       (rd_start),
        .rd_base        (rd_base),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid),
        .rd_done        (rd_done)
    );

    bind wb_top wb_top_assert u_assert (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .done     (done),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_done  (rd_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // outputs are settled and inputs may change here
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_row(input string name, input row_t got, input row_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errs++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic row_t idle_row();
        row_t r;
        for (int i = 0; i < DIM; i++)
            r[i] = elem_t'($random(seed));
        return r;
    endfunction

    // row r of a block holds element r of every lane
    function automatic row_t expected_row(input addr_t base, input int r);
        row_t row;
        for (int i = 0; i < DIM; i++)
            row[i] = ref_mem[i][addr_t'(base + r)];
        return row;
    endfunction

    // plays the array: lane i starts i cycles after lane 0
    task automatic write_block(input addr_t base);
        int   hold;
        int   done_cnt;
        int   k;
        row_t drive;
        done_cnt = 0;
        hold     = 2 + ($unsigned($random(seed)) % 4);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                cur_blk[i][j] = elem_t'($random(seed));
                ref_mem[i][addr_t'(base + j)] = cur_blk[i][j];
            end
        end
        wr_base = base;
        active  = 1'b1;
        next_cycle();                      // pulse sampled on this edge
        active = 1'b0;
        for (int s = 0; s <= DONE_RISE; s++) begin
            check_flag("done", done, logic'(s == DONE_RISE));
            if (done)
                done_cnt++;
            drive = idle_row();
            for (int i = 0; i < DIM; i++) begin
                k = s - 2 - i;             // element taken on edge t+3+i+k
                if (k >= 0 && k < DIM)
                    drive[i] = cur_blk[i][k];
            end
            res_data = drive;
            next_cycle();
        end
        for (int h = 0; h < hold; h++) begin   // done must hold on its own
            check_flag("done", done, 1'b1);
            if (done)
                done_cnt++;
            res_data = idle_row();
            next_cycle();
        end
        check_flag("done", done, 1'b1);
        if (done)
            done_cnt++;
        sys_arr_active = 1'b1;
        next_cycle();
        sys_arr_active = 1'b0;
        check_flag("done", done, 1'b0);
        check_count("done_cycles", done_cnt, hold + 2);
    endtask

    task automatic read_block(input addr_t base, input logic extra_start);
        int valid_cnt;
        int rdone_cnt;
        int row_idx;
        int extra_at;
        valid_cnt = 0;
        rdone_cnt = 0;
        row_idx   = 0;
        extra_at  = $unsigned($random(seed)) % (DIM - 1);
        rd_base   = base;
        rd_start  = 1'b1;
        next_cycle();
        rd_start = 1'b0;
        rd_base  = addr_t'($random(seed));  // must not disturb the running read
        for (int s = 0; s <= DIM + 2; s++) begin
            check_flag("rd_valid", rd_valid, logic'(s >= 1 && s <= DIM));
            check_flag("rd_done", rd_done, logic'(s == DIM));
            if (rd_valid) begin
                valid_cnt++;
                check_row("rd_data", rd_data, expected_row(base, row_idx));
                row_idx++;
            end
            if (rd_done)
                rdone_cnt++;
            rd_start = extra_start && (s == extra_at);
            next_cycle();
        end
        rd_start = 1'b0;
        check_count("rd_valid_cycles", valid_cnt, DIM);
        check_count("rd_done_pulses", rdone_cnt, 1);
    endtask

    initial begin
        bit slot_used [DIM];
        int slot;
        int j;
        int tmp;
        data_errs      = 0;
        flag_errs      = 0;
        count_errs     = 0;
        assert_errs    = 0;
        reset          = 1'b1;
        active         = 1'b0;
        sys_arr_active = 1'b0;
        wr_base        = '0;
        res_data       = '0;
        rd_start       = 1'b0;
        rd_base        = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        check_flag("done", done, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        check_flag("rd_done", rd_done, 1'b0);

        // distinct block slots so neighbors never overlap
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            slot = $unsigned($random(seed)) % DIM;
            while (slot_used[slot])
                slot = $unsigned($random(seed)) % DIM;
            slot_used[slot] = 1'b1;
            blk_base[b] = addr_t'(slot * DIM);
        end

        write_block(blk_base[0]);
        read_block(blk_base[0], 1'b1);

        for (int b = 1; b < NUM_BLOCKS; b++)
            write_block(blk_base[b]);

        for (int b = 0; b < NUM_BLOCKS; b++)
            rd_order[b] = b;
        for (int b = NUM_BLOCKS - 1; b > 0; b--) begin
            j           = $unsigned($random(seed)) % (b + 1);
            tmp         = rd_order[b];
            rd_order[b] = rd_order[j];
            rd_order[j] = tmp;
        end
        for (int b = 0; b < NUM_BLOCKS; b++)
            read_block(blk_base[rd_order[b]], logic'($random(seed) & 1));

        next_cycle();
        assert_errs = UUT.u_assert.fail_cnt;
        $display("errors: %0d data, %0d flag, %0d count, %0d assertion",
                 data_errs, flag_errs, count_errs, assert_errs);
        if (data_errs + flag_errs + count_errs + assert_errs == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles without the tests finishing", WDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* filelist.f */
design/sysarr_pkg.sv
design/wr_control.sv
design/rd_control.sv
design/mem_arr.sv
design/wb_top.sv
tb/wb_top_assert.sv
tb/wb_top_tb.sv

/* Bender.yml */
package:
  name: sysarr_wb

sources:
  - design/sysarr_pkg.sv
  - design/wr_control.sv
  - design/rd_control.sv
  - design/mem_arr.sv
  - design/wb_top.sv
  - target: test
    files:
      - tb/wb_top_assert.sv
      - tb/wb_top_tb.sv
